//--- verilog/qla_addr_pkg.sv
// ----------------------------------------------------------
// register bus address map: spaces, channel/offset fields
// and bit positions inside the board status word
// ----------------------------------------------------------
package qla_addr_pkg;

    // address bits 15:12
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0,   // board registers, the only decoded space
        ADDR_HUB  = 4'h1,
        ADDR_PROM = 4'h2,
        ADDR_ETH  = 4'h4,
        ADDR_FW   = 4'h5
    } addr_space_e;

    // ------------------------------------------------------
    // field positions in a 16-bit address
    // ------------------------------------------------------
    localparam int SPACE_BIT = 12;  // space, bits 15:12
    localparam int CHAN_BIT  = 4;   // channel, bits 7:4

    // per-axis offsets, bits 3:0
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;  // pot + current feedback
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;  // dac command

    // channel 0 offsets
    localparam logic [3:0] REG_STATUS = 4'd0;

    // ------------------------------------------------------
    // status word layout
    // ------------------------------------------------------
    // enables sit in the low bits, one per axis
    localparam int STAT_MASK_BIT = 8;   // write mask for the enables
    localparam int STAT_DIS_BIT  = 16;  // safety disables
    localparam int STAT_ID_BIT   = 24;  // board id

endpackage

//--- verilog/qla_bus_pkg.sv
// ----------------------------------------------------------
// write bus and real-time write structs, axis data types
// ----------------------------------------------------------
package qla_bus_pkg;

    localparam int NUM_AXES  = 4;
    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;
    localparam int SAMPLE_W  = 16;
    localparam int RT_ADDR_W = 3;   // rt addresses 0..4

    // safety check tuning
    localparam logic [SAMPLE_W-1:0] SAFETY_MARGIN = 16'h0100;
    localparam int                  SAFETY_CYCLES = 4;
    localparam logic [SAMPLE_W-1:0] MID_SCALE     = 16'h8000;  // zero current, offset binary

    // one register bus write, 49 bits
    typedef struct packed {
        logic              wen;
        logic [ADDR_W-1:0] waddr;
        logic [DATA_W-1:0] wdata;
    } reg_wr_t;

    // real-time block write from a host port, 36 bits
    typedef struct packed {
        logic                 wen;
        logic [RT_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]    wdata;
    } rt_wr_t;

    typedef logic [NUM_AXES-1:0][SAMPLE_W-1:0] axis_word_t;  // index 0 is axis 1
    typedef logic [NUM_AXES-1:0]               axis_bits_t;

endpackage

//--- verilog/wr_bus_arb.sv
// ----------------------------------------------------------
// write bus owner select: block writer, ethernet, firewire
// ----------------------------------------------------------
module wr_bus_arb (
    input  qla_bus_pkg::reg_wr_t fw_wr,
    input  qla_bus_pkg::reg_wr_t eth_wr,
    input  logic                 eth_write_en,  // ethernet owns the bus
    input  qla_bus_pkg::reg_wr_t bw_wr,
    input  logic                 bw_write_en,   // rt replay owns the bus
    output qla_bus_pkg::reg_wr_t reg_wr
);

    // fixed priority, whole struct switches at once
    // a lower master's strobe is simply dropped while it is not owner
    always_comb begin
        if (bw_write_en) begin
            reg_wr = bw_wr;
        end else if (eth_write_en) begin
            reg_wr = eth_wr;
        end else begin
            reg_wr = fw_wr;         // default owner
        end
    end

endmodule

//--- verilog/rt_block_write.sv
// ----------------------------------------------------------
// real-time block write: collects control + dac words,
// then replays them as five register bus writes
// ----------------------------------------------------------
module rt_block_write (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  qla_bus_pkg::rt_wr_t  fw_rt_wr,
    input  qla_bus_pkg::rt_wr_t  eth_rt_wr,
    output qla_bus_pkg::reg_wr_t bw_wr,
    output logic                 bw_write_en
);
    import qla_addr_pkg::*;
    import qla_bus_pkg::*;

    typedef enum logic {
        IDLE,
        REPLAY
    } rt_state_e;

    rt_state_e         state;
    logic [2:0]        step;       // 0..3 dac writes, 4 status write
    rt_wr_t            rt_wr;      // merged rt source
    logic [DATA_W-1:0] ctrl_word;
    axis_word_t        dac_word;

    // ethernet wins whenever it strobes
    assign rt_wr = eth_rt_wr.wen ? eth_rt_wr : fw_rt_wr;

    // ------------------------------------------------------
    // capture, only while idle
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (state == IDLE && rt_wr.wen) begin
            if (rt_wr.waddr == '0) begin
                ctrl_word <= rt_wr.wdata;
            end else if (rt_wr.waddr <= RT_ADDR_W'(NUM_AXES)) begin
                dac_word[2'(rt_wr.waddr - 3'd1)] <= rt_wr.wdata[SAMPLE_W-1:0];
            end
        end
    end

    // ------------------------------------------------------
    // replay FSM
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // last dac word kicks off the replay
                    if (rt_wr.wen && rt_wr.waddr == RT_ADDR_W'(NUM_AXES)) begin
                        state <= REPLAY;
                        step  <= '0;
                    end
                end
                REPLAY: begin
                    if (step == 3'(NUM_AXES)) begin
                        state <= IDLE;  // status write was the last one
                    end
                    step <= step + 3'd1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign bw_write_en = (state == REPLAY);

    // one write per replay cycle
    always_comb begin
        bw_wr = '0;
        bw_wr.wen = bw_write_en;
        bw_wr.waddr[SPACE_BIT +: 4] = ADDR_MAIN;
        if (step < 3'(NUM_AXES)) begin
            bw_wr.waddr[CHAN_BIT +: 4] = 4'(step) + 4'd1;   // axis n on channel n
            bw_wr.waddr[3:0] = OFF_DAC_CTRL;
            bw_wr.wdata[SAMPLE_W-1:0] = dac_word[step[1:0]];
        end else begin
            bw_wr.waddr[3:0] = REG_STATUS;                  // channel 0
            bw_wr.wdata = ctrl_word;
        end
    end

endmodule

//--- verilog/board_regs.sv
// ----------------------------------------------------------
// channel 0 board status register, amp enables and
// one-cycle enable pulses for the safety checks
// ----------------------------------------------------------
module board_regs (
    input  logic                            sysclk,
    input  logic                            rst_n,
    input  qla_bus_pkg::reg_wr_t            reg_wr,
    input  logic [3:0]                      board_id,
    input  qla_bus_pkg::axis_bits_t         safety_disable,
    output logic [qla_bus_pkg::DATA_W-1:0]  status_word,
    output qla_bus_pkg::axis_bits_t         amp_enable,
    output qla_bus_pkg::axis_bits_t         amp_enable_pulse
);
    import qla_addr_pkg::*;
    import qla_bus_pkg::*;

    logic       stat_wen;   // write hits REG_STATUS
    axis_bits_t wr_mask;
    axis_bits_t wr_en;
    axis_bits_t amp_en_reg; // stored enables

    assign stat_wen = reg_wr.wen
                    && reg_wr.waddr[SPACE_BIT +: 4] == ADDR_MAIN
                    && reg_wr.waddr[CHAN_BIT +: 4] == 4'd0
                    && reg_wr.waddr[3:0] == REG_STATUS;
    assign wr_mask = reg_wr.wdata[STAT_MASK_BIT +: NUM_AXES];
    assign wr_en   = reg_wr.wdata[NUM_AXES-1:0];

    // ------------------------------------------------------
    // enable register, masked per axis
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en_reg       <= '0;
            amp_enable_pulse <= '0;
        end else begin
            amp_enable_pulse <= '0;
            if (stat_wen) begin
                for (int i = 0; i < NUM_AXES; i++) begin
                    if (wr_mask[i]) begin
                        amp_en_reg[i]       <= wr_en[i];
                        amp_enable_pulse[i] <= wr_en[i];  // clears a latched disable
                    end
                end
            end
        end
    end

    // safety overrides the host
    assign amp_enable = amp_en_reg & ~safety_disable;

    always_comb begin
        status_word = '0;
        status_word[NUM_AXES-1:0]            = amp_en_reg;
        status_word[STAT_DIS_BIT +: NUM_AXES] = safety_disable;
        status_word[STAT_ID_BIT +: 4]        = board_id;
    end

endmodule

//--- verilog/ctrl_dac.sv
// ----------------------------------------------------------
// per-axis dac command registers, loaded over the bus
// ----------------------------------------------------------
module ctrl_dac (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  qla_bus_pkg::reg_wr_t    reg_wr,
    output qla_bus_pkg::axis_word_t dac_cmd
);
    import qla_addr_pkg::*;
    import qla_bus_pkg::*;

    logic [3:0] wr_chan;
    logic       dac_wen;
    logic [1:0] wr_axis;    // channel n -> axis index n-1

    assign wr_chan = reg_wr.waddr[CHAN_BIT +: 4];
    assign wr_axis = 2'(wr_chan - 4'd1);

    // main space, channel 1..4, dac offset
    assign dac_wen = reg_wr.wen
                   && reg_wr.waddr[SPACE_BIT +: 4] == ADDR_MAIN
                   && reg_wr.waddr[3:0] == OFF_DAC_CTRL
                   && wr_chan != 4'd0
                   && wr_chan <= 4'(NUM_AXES);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                dac_cmd[i] <= MID_SCALE;    // zero current
            end
        end else if (dac_wen) begin
            dac_cmd[wr_axis] <= reg_wr.wdata[SAMPLE_W-1:0];
        end
    end

endmodule

//--- verilog/safety_check.sv
// ----------------------------------------------------------
// per-axis overcurrent check with latched amp disable
// ----------------------------------------------------------
module safety_check (
    input  logic                             sysclk,
    input  logic                             rst_n,
    input  logic [qla_bus_pkg::SAMPLE_W-1:0] cur_in,   // adc feedback
    input  logic [qla_bus_pkg::SAMPLE_W-1:0] dac_in,   // commanded current
    input  logic                             clear_disable,
    output logic                             amp_disable
);
    import qla_bus_pkg::*;

    logic [SAMPLE_W-1:0] cur_mag;
    logic [SAMPLE_W-1:0] dac_mag;
    logic [SAMPLE_W+1:0] limit;     // 2*|cmd| + margin, no overflow
    logic                over;
    logic [2:0]          over_cnt;  // saturates at SAFETY_CYCLES

    // magnitudes around mid scale
    assign cur_mag = (cur_in >= MID_SCALE) ? cur_in - MID_SCALE : MID_SCALE - cur_in;
    assign dac_mag = (dac_in >= MID_SCALE) ? dac_in - MID_SCALE : MID_SCALE - dac_in;
    assign limit   = {1'b0, dac_mag, 1'b0} + (SAMPLE_W+2)'(SAFETY_MARGIN);
    assign over    = {2'b00, cur_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else begin
            if (!over) begin
                over_cnt <= '0;     // run broken, start again
            end else if (over_cnt != 3'(SAFETY_CYCLES)) begin
                over_cnt <= over_cnt + 3'd1;
            end
            // latch on the SAFETY_CYCLES-th overcurrent cycle in a row
            if (clear_disable) begin
                amp_disable <= 1'b0;
            end else if (over && over_cnt >= 3'(SAFETY_CYCLES - 1)) begin
                amp_disable <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/rd_bus_mux.sv
// ----------------------------------------------------------
// read address select and read data decode by space,
// channel and offset
// ----------------------------------------------------------
module rd_bus_mux (
    input  logic [qla_bus_pkg::ADDR_W-1:0] fw_raddr,
    input  logic [qla_bus_pkg::ADDR_W-1:0] eth_raddr,
    input  logic                           eth_read_en,
    input  logic [qla_bus_pkg::DATA_W-1:0] status_word,
    input  qla_bus_pkg::axis_word_t        dac_cmd,
    input  qla_bus_pkg::axis_word_t        cur_fb,
    input  qla_bus_pkg::axis_word_t        pot_fb,
    output logic [qla_bus_pkg::DATA_W-1:0] reg_rdata
);
    import qla_addr_pkg::*;
    import qla_bus_pkg::*;

    logic [ADDR_W-1:0] raddr;
    addr_space_e       space;
    logic [3:0]        chan;
    logic [1:0]        axis;

    assign raddr = eth_read_en ? eth_raddr : fw_raddr;  // ethernet takes the bus
    assign space = addr_space_e'(raddr[SPACE_BIT +: 4]);
    assign chan  = raddr[CHAN_BIT +: 4];
    assign axis  = 2'(chan - 4'd1);

    always_comb begin
        reg_rdata = '0;
        case (space)
            ADDR_MAIN: begin
                if (chan == 4'd0) begin
                    reg_rdata = status_word;
                end else if (chan <= 4'(NUM_AXES)) begin
                    case (raddr[3:0])
                        OFF_ADC_DATA: reg_rdata = {pot_fb[axis], cur_fb[axis]};
                        OFF_DAC_CTRL: reg_rdata = {{(DATA_W-SAMPLE_W){1'b0}}, dac_cmd[axis]};
                        default:      reg_rdata = '0;
                    endcase
                end
            end
            // spaces without a backing module
            default: reg_rdata = '0;
        endcase
    end

endmodule

//--- verilog/qla_top.sv
// ----------------------------------------------------------
// top level: write/read bus, rt block writer, board regs,
// dac commands and four axis safety checks
// ----------------------------------------------------------
module qla_top (
    input  logic                           sysclk,
    input  logic                           rst_n,
    input  logic [3:0]                     board_id,
    // write masters
    input  qla_bus_pkg::reg_wr_t           fw_wr,
    input  qla_bus_pkg::reg_wr_t           eth_wr,
    input  logic                           eth_write_en,
    input  qla_bus_pkg::rt_wr_t            fw_rt_wr,
    input  qla_bus_pkg::rt_wr_t            eth_rt_wr,
    // read ports
    input  logic [qla_bus_pkg::ADDR_W-1:0] fw_raddr,
    input  logic [qla_bus_pkg::ADDR_W-1:0] eth_raddr,
    input  logic                           eth_read_en,
    // axis feedback from the adcs
    input  qla_bus_pkg::axis_word_t        cur_fb,
    input  qla_bus_pkg::axis_word_t        pot_fb,
    output logic [qla_bus_pkg::DATA_W-1:0] reg_rdata,
    output qla_bus_pkg::axis_word_t        dac_cmd,
    output qla_bus_pkg::axis_bits_t        amp_enable,
    output qla_bus_pkg::axis_bits_t        safety_amp_disable
);
    import qla_bus_pkg::*;

    reg_wr_t           reg_wr;      // arbitrated write bus
    reg_wr_t           bw_wr;
    logic              bw_write_en;
    logic [DATA_W-1:0] status_word;
    axis_bits_t        amp_enable_pulse;

    // ------------------------------------------------------
    // write side
    // ------------------------------------------------------
    rt_block_write u_rt_write (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .fw_rt_wr    (fw_rt_wr),
        .eth_rt_wr   (eth_rt_wr),
        .bw_wr       (bw_wr),
        .bw_write_en (bw_write_en)
    );

    wr_bus_arb u_wr_arb (
        .fw_wr        (fw_wr),
        .eth_wr       (eth_wr),
        .eth_write_en (eth_write_en),
        .bw_wr        (bw_wr),
        .bw_write_en  (bw_write_en),
        .reg_wr       (reg_wr)
    );

    board_regs u_chan0 (
        .sysclk           (sysclk),
        .rst_n            (rst_n),
        .reg_wr           (reg_wr),
        .board_id         (board_id),
        .safety_disable   (safety_amp_disable),
        .status_word      (status_word),
        .amp_enable       (amp_enable),
        .amp_enable_pulse (amp_enable_pulse)
    );

    ctrl_dac u_dac (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .reg_wr  (reg_wr),
        .dac_cmd (dac_cmd)
    );

    // ------------------------------------------------------
    // read side, shared by both hosts
    // ------------------------------------------------------
    rd_bus_mux u_rd_mux (
        .fw_raddr    (fw_raddr),
        .eth_raddr   (eth_raddr),
        .eth_read_en (eth_read_en),
        .status_word (status_word),
        .dac_cmd     (dac_cmd),
        .cur_fb      (cur_fb),
        .pot_fb      (pot_fb),
        .reg_rdata   (reg_rdata)
    );

    // one overcurrent check per axis, cleared by its enable pulse
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_safe
        safety_check u_safe (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .cur_in        (cur_fb[i]),
            .dac_in        (dac_cmd[i]),
            .clear_disable (amp_enable_pulse[i]),
            .amp_disable   (safety_amp_disable[i])
        );
    end

endmodule

//--- dv/qla_top_tb.sv
// ----------------------------------------------------------
// testbench for qla_top: host writes and reads, write
// priority, rt block replay and axis safety disable
// ----------------------------------------------------------
module qla_top_tb;
    import qla_addr_pkg::*;
    import qla_bus_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 70 + 12 + 45 + 50;  // rough per-test sum
    localparam int REPLAY_LEN   = NUM_AXES + 1;     // four dac writes, one status write
    localparam int REPLAY_MAX   = 20;
    localparam int SAFE_AXIS    = 2;
    localparam logic [SAMPLE_W-1:0] CMD_OFFSET = 16'h0200;

    logic sysclk = 1'b0;
    logic rst_n;
    logic [3:0] board_id;
    reg_wr_t fw_wr;
    reg_wr_t eth_wr;
    logic eth_write_en;
    rt_wr_t fw_rt_wr;
    rt_wr_t eth_rt_wr;
    logic [ADDR_W-1:0] fw_raddr;
    logic [ADDR_W-1:0] eth_raddr;
    logic eth_read_en;
    axis_word_t cur_fb;
    axis_word_t pot_fb;
    logic [DATA_W-1:0] reg_rdata;
    axis_word_t dac_cmd;
    axis_bits_t amp_enable;
    axis_bits_t safety_amp_disable;

    integer seed = 32'he93df804;
    int error_count = 0;
    int check_count = 0;
    int replay_cycles = 0;
    int wait_cycles;
    string test_name = "reset";
    axis_word_t exp_dac;                        // model of the dac commands
    axis_word_t exp_pot;
    axis_word_t exp_cur;
    axis_bits_t ctrl_en;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] rt_data [NUM_AXES+1];    // rt address 0 is the control word
    logic [SAMPLE_W-1:0] over_val;

    qla_top dut0 (.*);

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    // ------------------------------------------------------
    // concurrent checks
    // ------------------------------------------------------
    replay_window: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(dut0.bw_write_en) |-> dut0.bw_write_en ##1 dut0.bw_write_en ##1 dut0.bw_write_en
            ##1 dut0.bw_write_en ##1 dut0.bw_write_en ##1 !dut0.bw_write_en)
        else begin
            error_count++;
            $display("ERROR %s: replay window is not %0d cycles long", test_name, REPLAY_LEN);
        end

    always @(negedge sysclk) begin
        if (rst_n === 1'b1 && dut0.bw_write_en === 1'b1) begin
            replay_cycles++;
        end
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", 2 * TEST_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------------
    // helpers
    // ------------------------------------------------------
    function automatic logic [ADDR_W-1:0] reg_addr(addr_space_e space, int chan,
                                                   logic [3:0] off);
        logic [ADDR_W-1:0] a;
        a = '0;
        a[SPACE_BIT +: 4] = space;
        a[CHAN_BIT +: 4]  = 4'(chan);
        a[3:0]            = off;
        return a;
    endfunction

    task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic fw_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge sysclk);
        fw_wr <= {1'b1, addr, data};
        @(posedge sysclk);          // write lands on this edge
        fw_wr.wen <= 1'b0;
    endtask

    // other port gets the inverted address as a decoy
    task automatic read_port(input logic use_eth, input logic [ADDR_W-1:0] addr,
                             output logic [DATA_W-1:0] data);
        @(posedge sysclk);
        eth_read_en <= use_eth;
        eth_raddr   <= use_eth ? addr : ~addr;
        fw_raddr    <= use_eth ? ~addr : addr;
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    // value is seen by `cycles` edges, the last one being the next driving edge
    task automatic hold_current(input int axis, input logic [SAMPLE_W-1:0] value,
                                input int cycles);
        @(posedge sysclk);
        cur_fb[axis] <= value;
        repeat (cycles - 1) @(posedge sysclk);
    endtask

    // ------------------------------------------------------
    // main sequence
    // ------------------------------------------------------
    initial begin
        rst_n        <= 1'b0;
        board_id     <= 4'($random(seed));
        fw_wr        <= '0;
        eth_wr       <= '0;
        eth_write_en <= 1'b0;
        fw_rt_wr     <= '0;
        eth_rt_wr    <= '0;
        fw_raddr     <= '0;
        eth_raddr    <= '0;
        eth_read_en  <= 1'b0;
        cur_fb       <= {NUM_AXES{MID_SCALE}};  // zero current
        pot_fb       <= '0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        rst_n <= 1'b1;
        @(negedge sysclk);
        for (int i = 0; i < NUM_AXES; i++) begin
            exp_dac[i] = MID_SCALE;
            check_value($sformatf("dac_cmd[%0d]", i), exp_dac[i], dac_cmd[i]);
        end
        check_value("amp_enable", '0, amp_enable);
        check_value("safety_amp_disable", '0, safety_amp_disable);

        test_name = "host_write";
        for (int n = 1; n <= NUM_AXES; n++) begin
            wr_data = $random(seed);
            fw_write(reg_addr(ADDR_MAIN, n, OFF_DAC_CTRL), wr_data);
            exp_dac[n-1] = wr_data[SAMPLE_W-1:0];
            @(negedge sysclk);
            check_value("dac_cmd", exp_dac[n-1], dac_cmd[n-1]);
            read_port(1'b0, reg_addr(ADDR_MAIN, n, OFF_DAC_CTRL), rd_data);
            check_value("fw dac readback", {16'h0, exp_dac[n-1]}, rd_data);
            read_port(1'b1, reg_addr(ADDR_MAIN, n, OFF_DAC_CTRL), rd_data);
            check_value("eth dac readback", {16'h0, exp_dac[n-1]}, rd_data);
        end

        test_name = "adc_read";
        @(posedge sysclk);
        for (int n = 0; n < NUM_AXES; n++) begin
            wr_data    = $random(seed);
            exp_pot[n] = wr_data[31:16];
            exp_cur[n] = MID_SCALE + {8'h00, wr_data[7:0]};  // inside the safety margin
            pot_fb[n] <= exp_pot[n];
            cur_fb[n] <= exp_cur[n];
        end
        for (int n = 0; n < NUM_AXES; n++) begin
            read_port(n[0], reg_addr(ADDR_MAIN, n + 1, OFF_ADC_DATA), rd_data);
            check_value("adc readback", {exp_pot[n], exp_cur[n]}, rd_data);
        end
        read_port(1'b0, reg_addr(ADDR_HUB, 1, OFF_DAC_CTRL), rd_data);
        check_value("hub space", '0, rd_data);
        read_port(1'b1, reg_addr(ADDR_FW, 1, OFF_ADC_DATA), rd_data);
        check_value("fw space", '0, rd_data);

        test_name = "write_priority";
        wr_data = $random(seed);
        @(posedge sysclk);
        eth_write_en <= 1'b1;
        fw_wr  <= {1'b1, reg_addr(ADDR_MAIN, 2, OFF_DAC_CTRL), ~wr_data};
        eth_wr <= {1'b1, reg_addr(ADDR_MAIN, 2, OFF_DAC_CTRL), wr_data};
        @(posedge sysclk);
        fw_wr.wen  <= 1'b0;
        eth_wr.wen <= 1'b0;
        exp_dac[1] = wr_data[SAMPLE_W-1:0];
        @(negedge sysclk);
        check_value("dac_cmd[1]", exp_dac[1], dac_cmd[1]);
        // firewire alone while ethernet still owns the bus
        fw_write(reg_addr(ADDR_MAIN, 3, OFF_DAC_CTRL), {16'h0, ~exp_dac[2]});
        @(negedge sysclk);
        check_value("dac_cmd[2]", exp_dac[2], dac_cmd[2]);
        @(posedge sysclk);
        eth_write_en <= 1'b0;

        test_name = "rt_replay";
        wr_data = $random(seed);
        ctrl_en = wr_data[NUM_AXES-1:0];
        rt_data[0] = (32'hF << STAT_MASK_BIT) | 32'(ctrl_en);
        for (int a = 1; a <= NUM_AXES; a++) begin
            rt_data[a] = $random(seed);
        end
        replay_cycles = 0;
        for (int a = 0; a <= NUM_AXES; a++) begin
            @(posedge sysclk);
            if (a == 2) begin
                fw_rt_wr  <= {1'b1, 3'(a), ~rt_data[a]};   // loses to ethernet
                eth_rt_wr <= {1'b1, 3'(a), rt_data[a]};
            end else begin
                fw_rt_wr      <= {1'b1, 3'(a), rt_data[a]};
                eth_rt_wr.wen <= 1'b0;
            end
        end
        @(posedge sysclk);          // address 4 captured, replay starts
        fw_rt_wr.wen <= 1'b0;
        @(posedge sysclk);
        fw_wr    <= {1'b1, reg_addr(ADDR_MAIN, 1, OFF_DAC_CTRL), ~rt_data[1]};
        fw_rt_wr <= {1'b1, 3'(NUM_AXES), ~rt_data[NUM_AXES]};
        @(posedge sysclk);
        fw_wr.wen    <= 1'b0;
        fw_rt_wr.wen <= 1'b0;
        wait_cycles = 0;
        @(negedge sysclk);
        while (dut0.bw_write_en !== 1'b0 && wait_cycles < REPLAY_MAX) begin
            @(negedge sysclk);
            wait_cycles++;
        end
        if (dut0.bw_write_en !== 1'b0) begin
            error_count++;
            $display("ERROR %s: replay still running after %0d cycles", test_name, REPLAY_MAX);
        end
        repeat (3) @(posedge sysclk);   // room for a second replay, there must be none
        @(negedge sysclk);
        check_value("replay cycles", REPLAY_LEN, replay_cycles);
        for (int i = 0; i < NUM_AXES; i++) begin
            exp_dac[i] = rt_data[i+1][SAMPLE_W-1:0];
            check_value($sformatf("dac_cmd[%0d]", i), exp_dac[i], dac_cmd[i]);
        end
        check_value("amp_enable", 32'(ctrl_en), amp_enable);
        read_port(1'b1, reg_addr(ADDR_MAIN, 0, REG_STATUS), rd_data);
        check_value("status", (32'(board_id) << STAT_ID_BIT) | 32'(ctrl_en), rd_data);

        test_name = "safety";
        fw_write(reg_addr(ADDR_MAIN, 0, REG_STATUS), (32'hF << STAT_MASK_BIT) | 32'hF);
        exp_dac[SAFE_AXIS] = MID_SCALE + CMD_OFFSET;
        fw_write(reg_addr(ADDR_MAIN, SAFE_AXIS + 1, OFF_DAC_CTRL), {16'h0, exp_dac[SAFE_AXIS]});
        hold_current(SAFE_AXIS, MID_SCALE, 2);
        @(negedge sysclk);
        check_value("amp_enable", 32'hF, amp_enable);
        over_val = MID_SCALE - (2 * CMD_OFFSET + SAFETY_MARGIN + 16'h0040);  // past 2|cmd|+margin
        hold_current(SAFE_AXIS, over_val, SAFETY_CYCLES - 1);
        hold_current(SAFE_AXIS, MID_SCALE, 1);
        hold_current(SAFE_AXIS, over_val, SAFETY_CYCLES - 1);
        hold_current(SAFE_AXIS, MID_SCALE, 2);
        @(negedge sysclk);
        check_value("disable after short runs", '0, safety_amp_disable);
        hold_current(SAFE_AXIS, over_val, SAFETY_CYCLES);
        @(negedge sysclk);
        check_value("disable one cycle early", '0, safety_amp_disable);
        @(posedge sysclk);          // last overcurrent edge of the run
        @(negedge sysclk);
        check_value("safety_amp_disable", 32'(1 << SAFE_AXIS), safety_amp_disable);
        check_value("amp_enable", 32'hF & ~32'(1 << SAFE_AXIS), amp_enable);
        read_port(1'b0, reg_addr(ADDR_MAIN, 0, REG_STATUS), rd_data);
        check_value("status", (32'(board_id) << STAT_ID_BIT)
                    | (32'(1 << SAFE_AXIS) << STAT_DIS_BIT) | 32'hF, rd_data);
        hold_current(SAFE_AXIS, MID_SCALE, 2);
        @(negedge sysclk);
        check_value("disable holds", 32'(1 << SAFE_AXIS), safety_amp_disable);
        fw_write(reg_addr(ADDR_MAIN, 0, REG_STATUS),
                 32'(1 << (STAT_MASK_BIT + SAFE_AXIS)) | 32'(1 << SAFE_AXIS));
        @(posedge sysclk);          // enable pulse reaches the check
        @(negedge sysclk);
        check_value("disable cleared", '0, safety_amp_disable);
        check_value("amp_enable", 32'hF, amp_enable);

        repeat (2) @(posedge sysclk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- qla_top.f
verilog/qla_addr_pkg.sv
verilog/qla_bus_pkg.sv
verilog/wr_bus_arb.sv
verilog/rt_block_write.sv
verilog/board_regs.sv
verilog/ctrl_dac.sv
verilog/safety_check.sv
verilog/rd_bus_mux.sv
verilog/qla_top.sv
dv/qla_top_tb.sv

//--- Bender.yml
package:
  name: qla_top

sources:
  # packages first, then rtl bottom up
  - files:
      - verilog/qla_addr_pkg.sv
      - verilog/qla_bus_pkg.sv
      - verilog/wr_bus_arb.sv
      - verilog/rt_block_write.sv
      - verilog/board_regs.sv
      - verilog/ctrl_dac.sv
      - verilog/safety_check.sv
      - verilog/rd_bus_mux.sv
      - verilog/qla_top.sv
  - target: test
    files:
      - dv/qla_top_tb.sv
